//--- cdc_fifo_credit.f
+incdir+verilog
+incdir+test
verilog/cdc_fifo_pkg.sv
verilog/cdc_fifo_gray_sync.sv
verilog/cdc_fifo_push_ctrl_credit.sv
verilog/cdc_fifo_pop_ctrl.sv
verilog/cdc_fifo_ram.sv
verilog/cdc_fifo_credit.sv
test/cdc_fifo_credit_tb.sv

//--- test/cdc_fifo_credit_tasks.svh
// Directed test tasks and wait helpers of the credit FIFO testbench
`ifndef CDC_FIFO_CREDIT_TASKS_SVH
`define CDC_FIFO_CREDIT_TASKS_SVH

// --------------------------------------------------
// Helpers
// --------------------------------------------------
task automatic check_value(input string what, input int got, input int expected);
  check_count++;
  if (got != expected) begin
    report_error($sformatf("%s is %0d, expected %0d", what, got, expected));
  end
endtask

function automatic int push_status(input int what);
  case (what)
    ST_GRANTED: return credits_granted;
    ST_SENT:    return sent_total;
    ST_FULL:    return int'(full);
    ST_HELD:    return sender_credits;
    default:    return exp_q.size();
  endcase
endfunction

// Sampled on the falling push_clk edge
task automatic wait_push(input int what, input int target, input int limit, input string name);
  int cycles;
  cycles = 0;
  while (push_status(what) != target && cycles < limit) begin
    @(negedge push_clk);
    cycles++;
  end
  if (push_status(what) != target) begin
    report_timeout($sformatf("%s to reach %0d", name, target));
  end
endtask

task automatic watch_no_credit(input int cycles);
  repeat (cycles) begin
    @(negedge push_clk);
    if (push_credit) begin
      report_error("push_credit high where no credit may be granted");
    end
  end
endtask

// Rst held for eight push_clk cycles and several pop_clk edges
task automatic apply_reset(input int initial_credits, input int withhold, input logic stall);
  @(posedge push_clk);
  rst                  <= 1'b1;
  credit_initial_push  <= cdc_fifo_pkg::credit_t'(initial_credits);
  credit_withhold_push <= cdc_fifo_pkg::credit_t'(withhold);
  push_credit_stall    <= stall;
  send_req             <= 0;
  pop_mode             <= POP_HOLD;
  @(negedge push_clk);
  word_q.delete();
  exp_q.delete();
  repeat (RESET_CYCLES) @(posedge push_clk);
  rst <= 1'b0;
endtask

// Words go in the queue first and the request count follows on a rising edge
task automatic queue_words(input int count, input int base, input bit random_data);
  cdc_fifo_pkg::data_t word;
  @(negedge push_clk);
  for (int i = 0; i < count; i++) begin
    if (random_data) begin
      word = cdc_fifo_pkg::data_t'($urandom());
    end else begin
      word = cdc_fifo_pkg::data_t'(base + i);
    end
    word_q.push_back(word);
  end
  @(posedge push_clk);
  send_req <= send_req + count;
endtask

// --------------------------------------------------
// Directed tests
// --------------------------------------------------
task automatic reset_credit_return();
  apply_reset(`CDC_FIFO_DEPTH, 0, 1'b0);
  @(negedge push_clk);
  check_value("push_credit after reset", push_credit, 0);
  check_value("slots after reset", slots, `CDC_FIFO_DEPTH);
  check_value("full after reset", full, 0);
  check_value("empty after reset", empty, 1);
  check_value("credit_count_push after reset", credit_count_push, `CDC_FIFO_DEPTH);
  wait_push(ST_GRANTED, `CDC_FIFO_DEPTH, WAIT_CYCLES, "initial credits");
  watch_no_credit(WINDOW_CYCLES);
  check_value("credits returned", credits_granted, `CDC_FIFO_DEPTH);
  check_value("credit_count_push when drained", credit_count_push, 0);
endtask

task automatic withhold_credits(input int withhold);
  apply_reset(`CDC_FIFO_DEPTH, withhold, 1'b0);
  // Full count loaded, only the part above the withhold is available
  @(negedge push_clk);
  check_value("credit_count_push with withhold", credit_count_push, `CDC_FIFO_DEPTH);
  check_value("credit_available_push with withhold", credit_available_push,
              `CDC_FIFO_DEPTH - withhold);
  wait_push(ST_GRANTED, `CDC_FIFO_DEPTH - withhold, WAIT_CYCLES, "unwithheld credits");
  watch_no_credit(WINDOW_CYCLES);
  check_value("credits under withhold", credits_granted, `CDC_FIFO_DEPTH - withhold);
  check_value("credit_count_push under withhold", credit_count_push, withhold);
  check_value("credit_available_push under withhold", credit_available_push, 0);
  // Releasing the withhold frees the rest
  @(posedge push_clk);
  credit_withhold_push <= '0;
  @(negedge push_clk);
  check_value("credit_available_push after release", credit_available_push, withhold);
  wait_push(ST_GRANTED, `CDC_FIFO_DEPTH, WAIT_CYCLES, "withheld credits");
  watch_no_credit(WINDOW_CYCLES);
  check_value("credits after release", credits_granted, `CDC_FIFO_DEPTH);
endtask

task automatic stall_credits();
  apply_reset(`CDC_FIFO_DEPTH, 0, 1'b1);
  watch_no_credit(WINDOW_CYCLES);
  check_value("credits during stall", credits_granted, 0);
  check_value("credit_count_push during stall", credit_count_push, `CDC_FIFO_DEPTH);
  @(posedge push_clk);
  push_credit_stall <= 1'b0;
  wait_push(ST_GRANTED, `CDC_FIFO_DEPTH, WAIT_CYCLES, "credits after stall");
endtask

task automatic fill_until_full();
  int cycles;
  apply_reset(`CDC_FIFO_DEPTH, 0, 1'b0);
  wait_push(ST_GRANTED, `CDC_FIFO_DEPTH, WAIT_CYCLES, "credits before fill");
  queue_words(`CDC_FIFO_DEPTH, 16'hc300, 1'b0);
  wait_push(ST_SENT, `CDC_FIFO_DEPTH, WAIT_CYCLES, "fill pushes");
  wait_push(ST_FULL, 1, WAIT_CYCLES, "full");
  check_value("slots when full", slots, 0);
  // Items seen from the pop side
  cycles = 0;
  while (items != cdc_fifo_pkg::count_t'(`CDC_FIFO_DEPTH) && cycles < WAIT_CYCLES) begin
    @(negedge pop_clk);
    cycles++;
  end
  check_value("items when full", items, `CDC_FIFO_DEPTH);
  check_value("empty when full", empty, 0);
  watch_no_credit(WINDOW_CYCLES);
  check_value("credits while full", credits_granted, `CDC_FIFO_DEPTH);
  @(posedge push_clk);
  pop_mode <= POP_TAKE;
  wait_push(ST_LEFT, 0, WAIT_CYCLES, "fill words to drain");
  wait_push(ST_GRANTED, 2 * `CDC_FIFO_DEPTH, WAIT_CYCLES, "credits after drain");
  check_value("sender credits after drain", sender_credits, `CDC_FIFO_DEPTH);
endtask

task automatic ordered_transfer();
  apply_reset(`CDC_FIFO_DEPTH, 0, 1'b0);
  @(posedge push_clk);
  pop_mode <= POP_TAKE;
  queue_words(20, 16'h5a00, 1'b0);
  wait_push(ST_SENT, 20, WAIT_CYCLES, "ordered pushes");
  wait_push(ST_LEFT, 0, DRAIN_CYCLES, "ordered words to drain");
  check_value("ordered words popped", popped_total, 20);
endtask

task automatic random_traffic();
  apply_reset(`CDC_FIFO_DEPTH, 0, 1'b0);
  // Consumer ready about two cycles in three
  for (int i = 0; i < 256; i++) begin
    ready_pat[i] = ($urandom() % 3) != 0;
  end
  queue_words(RANDOM_WORDS, 0, 1'b1);
  @(posedge push_clk);
  pop_mode <= POP_RANDOM;
  wait_push(ST_SENT, RANDOM_WORDS, DRAIN_CYCLES, "random pushes");
  wait_push(ST_LEFT, 0, DRAIN_CYCLES, "random words to drain");
  wait_push(ST_HELD, `CDC_FIFO_DEPTH, WAIT_CYCLES, "all credits back at the sender");
  check_value("random words popped", popped_total, RANDOM_WORDS);
  check_value("sender credits at end", sender_credits, `CDC_FIFO_DEPTH);
endtask

`endif

//--- test/cdc_fifo_credit_tb.sv
// Testbench for the dual-clock credit FIFO with sender credit model, scoreboard and watchdog
`include "cdc_fifo_macros.svh"

module cdc_fifo_credit_tb;

  // --------------------------------------------------
  // Timing and run length
  // --------------------------------------------------
  localparam int PUSH_HALF     = 4;
  localparam int POP_HALF      = 6;
  localparam int RESET_CYCLES  = 8;
  // Bounds below are push_clk cycles
  localparam int WAIT_CYCLES   = 200;
  localparam int WINDOW_CYCLES = 30;
  localparam int DRAIN_CYCLES  = 4000;
  localparam int RANDOM_WORDS  = 200;
  // Six resets, bounded waits and quiet windows
  localparam int RUN_CYCLES    = 6 * (RESET_CYCLES + 2) + 14 * WAIT_CYCLES
                               + 5 * WINDOW_CYCLES + 3 * DRAIN_CYCLES;
  localparam int WATCHDOG_TIME = (RUN_CYCLES + 500) * 2 * PUSH_HALF;

  // Push-side quantities a test can wait on
  localparam int ST_GRANTED = 0;
  localparam int ST_SENT    = 1;
  localparam int ST_FULL    = 2;
  localparam int ST_HELD    = 3;
  localparam int ST_LEFT    = 4;

  // Consumer behavior
  localparam int POP_HOLD   = 0;
  localparam int POP_TAKE   = 1;
  localparam int POP_RANDOM = 2;

  logic                  push_clk = 1'b0;
  logic                  pop_clk  = 1'b0;
  logic                  rst;
  logic                  push_credit_stall;
  logic                  push_valid = 1'b0;
  cdc_fifo_pkg::data_t   push_data  = '0;
  cdc_fifo_pkg::credit_t credit_initial_push;
  cdc_fifo_pkg::credit_t credit_withhold_push;
  logic                  pop_ready  = 1'b0;
  logic                  push_credit;
  logic                  full;
  cdc_fifo_pkg::count_t  slots;
  cdc_fifo_pkg::credit_t credit_count_push;
  cdc_fifo_pkg::credit_t credit_available_push;
  logic                  pop_valid;
  cdc_fifo_pkg::data_t   pop_data;
  logic                  empty;
  cdc_fifo_pkg::count_t  items;

  // Sender model and scoreboard state
  int                  error_count = 0;
  int                  check_count = 0;
  int                  send_req;
  int                  sent_total;
  int                  sender_credits;
  int                  credits_granted;
  int                  popped_total;
  int                  pop_mode;
  int                  ready_idx;
  cdc_fifo_pkg::data_t word_q [$];
  cdc_fifo_pkg::data_t exp_q [$];
  cdc_fifo_pkg::data_t sent_word;
  cdc_fifo_pkg::data_t expected_word;
  logic                ready_pat [256];

  always #(PUSH_HALF) push_clk = ~push_clk;
  always #(POP_HALF) pop_clk = ~pop_clk;

  cdc_fifo_credit UUT (
    .push_clk              (push_clk),
    .pop_clk               (pop_clk),
    .rst                   (rst),
    .push_credit_stall     (push_credit_stall),
    .push_credit           (push_credit),
    .push_valid            (push_valid),
    .push_data             (push_data),
    .credit_initial_push   (credit_initial_push),
    .credit_withhold_push  (credit_withhold_push),
    .full                  (full),
    .slots                 (slots),
    .credit_count_push     (credit_count_push),
    .credit_available_push (credit_available_push),
    .pop_ready             (pop_ready),
    .pop_valid             (pop_valid),
    .pop_data              (pop_data),
    .empty                 (empty),
    .items                 (items)
  );

  task automatic report_error(input string msg);
    error_count++;
    $display("ERROR at time %0t: %s", $time, msg);
  endtask

  task automatic report_timeout(input string msg);
    error_count++;
    $display("Gave up at time %0t while waiting for %s", $time, msg);
  endtask

  `include "cdc_fifo_credit_tasks.svh"

  // --------------------------------------------------
  // Sender, one credit per push
  // --------------------------------------------------
  always @(posedge push_clk) begin
    if (rst) begin
      sender_credits  = 0;
      credits_granted = 0;
      sent_total      = 0;
      push_valid     <= 1'b0;
    end else begin
      if (push_credit) begin
        sender_credits  = sender_credits + 1;
        credits_granted = credits_granted + 1;
      end
      if (sender_credits > 0 && sent_total < send_req && word_q.size() > 0) begin
        sent_word      = word_q.pop_front();
        exp_q.push_back(sent_word);
        sender_credits = sender_credits - 1;
        sent_total     = sent_total + 1;
        push_valid    <= 1'b1;
        push_data     <= sent_word;
      end else begin
        push_valid <= 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // Consumer and scoreboard check
  // --------------------------------------------------
  always @(posedge pop_clk) begin
    if (rst) begin
      popped_total = 0;
      ready_idx    = 0;
      pop_ready   <= 1'b0;
    end else begin
      if (pop_valid && pop_ready) begin
        popped_total = popped_total + 1;
        check_count  = check_count + 1;
        if (exp_q.size() == 0) begin
          report_error("pop transfer with no pushed word outstanding");
        end else begin
          expected_word = exp_q.pop_front();
          if (pop_data !== expected_word) begin
            report_error($sformatf("pop_data %h, expected %h", pop_data, expected_word));
          end
        end
      end
      case (pop_mode)
        POP_TAKE: pop_ready <= 1'b1;
        POP_RANDOM: begin
          pop_ready <= ready_pat[ready_idx % 256];
          ready_idx  = ready_idx + 1;
        end
        default: pop_ready <= 1'b0;
      endcase
    end
  end

  // Hard stop if a wait never returns
  initial begin
    #(WATCHDOG_TIME);
    $display("Watchdog expired at time %0t before the tests finished", $time);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    void'($urandom(66));
    rst                  = 1'b1;
    push_credit_stall    = 1'b0;
    credit_initial_push  = cdc_fifo_pkg::credit_t'(`CDC_FIFO_DEPTH);
    credit_withhold_push = '0;
    send_req             = 0;
    pop_mode             = POP_HOLD;
    reset_credit_return();
    withhold_credits(3);
    stall_credits();
    fill_until_full();
    ordered_transfer();
    random_traffic();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/cdc_fifo_credit.sv
// Top level of the dual-clock credit FIFO joining controllers, RAM and gray synchronizers
module cdc_fifo_credit (
  input  logic                  push_clk,
  input  logic                  pop_clk,
  input  logic                  rst,

  // Push side, push_clk domain
  input  logic                  push_credit_stall,
  output logic                  push_credit,
  input  logic                  push_valid,
  input  cdc_fifo_pkg::data_t   push_data,
  input  cdc_fifo_pkg::credit_t credit_initial_push,
  input  cdc_fifo_pkg::credit_t credit_withhold_push,
  output logic                  full,
  output cdc_fifo_pkg::count_t  slots,
  output cdc_fifo_pkg::credit_t credit_count_push,
  output cdc_fifo_pkg::credit_t credit_available_push,

  // Pop side, pop_clk domain
  input  logic                  pop_ready,
  output logic                  pop_valid,
  output cdc_fifo_pkg::data_t   pop_data,
  output logic                  empty,
  output cdc_fifo_pkg::count_t  items
);

  logic                 ram_wr_valid;
  cdc_fifo_pkg::addr_t  ram_wr_addr;
  cdc_fifo_pkg::data_t  ram_wr_data;
  logic                 ram_rd_valid;
  cdc_fifo_pkg::addr_t  ram_rd_addr;
  cdc_fifo_pkg::data_t  ram_rd_data;

  // Gray counts leaving each domain, binary counts arriving
  cdc_fifo_pkg::count_t push_count_gray;
  cdc_fifo_pkg::count_t pop_count_gray;
  cdc_fifo_pkg::count_t push_count_bin;
  cdc_fifo_pkg::count_t pop_count_bin;

  // --------------------------------------------------
  // Push domain
  // --------------------------------------------------
  cdc_fifo_push_ctrl_credit u_push_ctrl (
    .push_clk              (push_clk),
    .rst                   (rst),
    .push_credit_stall     (push_credit_stall),
    .push_credit           (push_credit),
    .push_valid            (push_valid),
    .push_data             (push_data),
    .full                  (full),
    .slots                 (slots),
    .credit_initial_push   (credit_initial_push),
    .credit_withhold_push  (credit_withhold_push),
    .credit_count_push     (credit_count_push),
    .credit_available_push (credit_available_push),
    .ram_wr_valid          (ram_wr_valid),
    .ram_wr_addr           (ram_wr_addr),
    .ram_wr_data           (ram_wr_data),
    .pop_count_bin         (pop_count_bin),
    .push_count_gray       (push_count_gray)
  );

  // Pop count into push_clk
  cdc_fifo_gray_sync u_sync_pop_to_push (
    .clk     (push_clk),
    .rst     (rst),
    .gray_in (pop_count_gray),
    .bin_out (pop_count_bin)
  );

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------
  cdc_fifo_ram u_ram (
    .push_clk     (push_clk),
    .pop_clk      (pop_clk),
    .ram_wr_valid (ram_wr_valid),
    .ram_wr_addr  (ram_wr_addr),
    .ram_wr_data  (ram_wr_data),
    .ram_rd_valid (ram_rd_valid),
    .ram_rd_addr  (ram_rd_addr),
    .ram_rd_data  (ram_rd_data)
  );

  // --------------------------------------------------
  // Pop domain
  // --------------------------------------------------
  // Push count into pop_clk
  cdc_fifo_gray_sync u_sync_push_to_pop (
    .clk     (pop_clk),
    .rst     (rst),
    .gray_in (push_count_gray),
    .bin_out (push_count_bin)
  );

  cdc_fifo_pop_ctrl u_pop_ctrl (
    .pop_clk        (pop_clk),
    .rst            (rst),
    .pop_ready      (pop_ready),
    .pop_valid      (pop_valid),
    .pop_data       (pop_data),
    .empty          (empty),
    .items          (items),
    .ram_rd_valid   (ram_rd_valid),
    .ram_rd_addr    (ram_rd_addr),
    .ram_rd_data    (ram_rd_data),
    .push_count_bin (push_count_bin),
    .pop_count_gray (pop_count_gray)
  );

endmodule

//--- verilog/cdc_fifo_gray_sync.sv
// Multi-flop synchronizer for a gray count with registered gray-to-binary conversion
`include "cdc_fifo_macros.svh"

module cdc_fifo_gray_sync (
  input  logic                 clk,
  input  logic                 rst,
  input  cdc_fifo_pkg::count_t gray_in,
  output cdc_fifo_pkg::count_t bin_out
);

  // Synchronizer chain, stage 0 sees the foreign clock domain
  cdc_fifo_pkg::count_t sync_q [`CDC_FIFO_SYNC_STAGES];
  cdc_fifo_pkg::count_t gray_synced;
  cdc_fifo_pkg::count_t bin_next;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CDC_FIFO_SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= gray_in;
      for (int i = 1; i < `CDC_FIFO_SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign gray_synced = sync_q[`CDC_FIFO_SYNC_STAGES-1];

  // Gray to binary, each bit is the xor of all gray bits above and at it
  always_comb begin
    bin_next[`CDC_FIFO_COUNT_WIDTH-1] = gray_synced[`CDC_FIFO_COUNT_WIDTH-1];
    for (int i = `CDC_FIFO_COUNT_WIDTH - 2; i >= 0; i--) begin
      bin_next[i] = bin_next[i+1] ^ gray_synced[i];
    end
  end

  // Conversion register, one more destination cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      bin_out <= '0;
    end else begin
      bin_out <= bin_next;
    end
  end

endmodule

//--- verilog/cdc_fifo_macros.svh
// Depth, width, credit and synchronizer-stage parameters of the dual-clock FIFO
`ifndef CDC_FIFO_MACROS_SVH
`define CDC_FIFO_MACROS_SVH

// --------------------------------------------------
// Storage geometry
// --------------------------------------------------
// Entries in the RAM
`define CDC_FIFO_DEPTH 8
// Data word width
`define CDC_FIFO_WIDTH 16
// RAM address bits
`define CDC_FIFO_ADDR_WIDTH $clog2(`CDC_FIFO_DEPTH)
// Push and pop counts carry one extra wrap bit
`define CDC_FIFO_COUNT_WIDTH ($clog2(`CDC_FIFO_DEPTH) + 1)

// --------------------------------------------------
// Credits and clock crossing
// --------------------------------------------------
// Largest number of credits the receiver can hold
`define CDC_FIFO_MAX_CREDIT `CDC_FIFO_DEPTH
// Bits needed to hold MAX_CREDIT itself
`define CDC_FIFO_CREDIT_WIDTH $clog2(`CDC_FIFO_MAX_CREDIT + 1)
// Flops in each gray count synchronizer
`define CDC_FIFO_SYNC_STAGES 2

`endif

//--- verilog/cdc_fifo_pkg.sv
// Address, count, credit and data types shared by the dual-clock FIFO
`include "cdc_fifo_macros.svh"

package cdc_fifo_pkg;

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------
  // RAM entry index
  typedef logic [`CDC_FIFO_ADDR_WIDTH-1:0] addr_t;

  // One stored word
  typedef logic [`CDC_FIFO_WIDTH-1:0] data_t;

  // --------------------------------------------------
  // Counts and credits
  // --------------------------------------------------
  // Push or pop count, wrap bit on top
  // Same width whether carried as binary or as gray
  typedef logic [`CDC_FIFO_COUNT_WIDTH-1:0] count_t;

  // Credit quantity, holds zero through MAX_CREDIT
  typedef logic [`CDC_FIFO_CREDIT_WIDTH-1:0] credit_t;

endpackage

//--- verilog/cdc_fifo_pop_ctrl.sv
// Pop controller with read addressing, valid/ready output register, pop gray count and flags
`include "cdc_fifo_macros.svh"

module cdc_fifo_pop_ctrl (
  input  logic                 pop_clk,
  input  logic                 rst,

  // Valid/ready pop interface
  input  logic                 pop_ready,
  output logic                 pop_valid,
  output cdc_fifo_pkg::data_t  pop_data,

  // Pop-side status
  output logic                 empty,
  output cdc_fifo_pkg::count_t items,

  // RAM read port, data one cycle after the request
  output logic                 ram_rd_valid,
  output cdc_fifo_pkg::addr_t  ram_rd_addr,
  input  cdc_fifo_pkg::data_t  ram_rd_data,

  // Counts to and from the push domain
  input  cdc_fifo_pkg::count_t push_count_bin,
  output cdc_fifo_pkg::count_t pop_count_gray
);

  // Read count walks the RAM, pop count only moves on a transfer
  cdc_fifo_pkg::count_t rd_count;
  cdc_fifo_pkg::count_t pop_count;
  cdc_fifo_pkg::count_t pop_count_next;
  cdc_fifo_pkg::count_t items_next;
  logic                 rd_pending;
  logic                 pop_beat;

  // --------------------------------------------------
  // RAM read issue
  // --------------------------------------------------
  assign pop_beat = pop_valid && pop_ready;

  // Unread word present, nothing in flight, output free next cycle
  assign ram_rd_valid = (push_count_bin != rd_count) && !rd_pending &&
                        (!pop_valid || pop_ready);
  assign ram_rd_addr  = rd_count[`CDC_FIFO_ADDR_WIDTH-1:0];

  always_ff @(posedge pop_clk) begin
    if (rst) begin
      rd_count   <= '0;
      rd_pending <= 1'b0;
    end else begin
      rd_count   <= rd_count + cdc_fifo_pkg::count_t'(ram_rd_valid);
      rd_pending <= ram_rd_valid;
    end
  end

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------
  // Returning word always lands in an empty register
  always_ff @(posedge pop_clk) begin
    if (rst) begin
      pop_valid <= 1'b0;
    end else if (rd_pending) begin
      pop_valid <= 1'b1;
    end else if (pop_ready) begin
      pop_valid <= 1'b0;
    end
  end

  // Held while the consumer stalls
  always_ff @(posedge pop_clk) begin
    if (rd_pending) begin
      pop_data <= ram_rd_data;
    end
  end

  // --------------------------------------------------
  // Pop count and flags
  // --------------------------------------------------
  // Slot is freed only once the consumer takes the word
  assign pop_count_next = pop_count + cdc_fifo_pkg::count_t'(pop_beat);
  assign items_next     = push_count_bin - pop_count_next;

  always_ff @(posedge pop_clk) begin
    if (rst) begin
      pop_count      <= '0;
      pop_count_gray <= '0;
      items          <= '0;
      empty          <= 1'b1;
    end else begin
      pop_count      <= pop_count_next;
      pop_count_gray <= pop_count_next ^ (pop_count_next >> 1);
      // Includes words still in the read pipe or the output register
      items          <= items_next;
      empty          <= (items_next == '0);
    end
  end

endmodule

//--- verilog/cdc_fifo_push_ctrl_credit.sv
// Push controller with credit receiver, write addressing, push gray count and push-side flags
`include "cdc_fifo_macros.svh"

module cdc_fifo_push_ctrl_credit (
  input  logic                  push_clk,
  input  logic                  rst,

  // Credit/valid push interface
  input  logic                  push_credit_stall,
  output logic                  push_credit,
  input  logic                  push_valid,
  input  cdc_fifo_pkg::data_t   push_data,

  // Push-side status
  output logic                  full,
  output cdc_fifo_pkg::count_t  slots,

  // Credit control and observation
  input  cdc_fifo_pkg::credit_t credit_initial_push,
  input  cdc_fifo_pkg::credit_t credit_withhold_push,
  output cdc_fifo_pkg::credit_t credit_count_push,
  output cdc_fifo_pkg::credit_t credit_available_push,

  // RAM write port
  output logic                  ram_wr_valid,
  output cdc_fifo_pkg::addr_t   ram_wr_addr,
  output cdc_fifo_pkg::data_t   ram_wr_data,

  // Counts to and from the pop domain
  input  cdc_fifo_pkg::count_t  pop_count_bin,
  output cdc_fifo_pkg::count_t  push_count_gray
);

  cdc_fifo_pkg::count_t  push_count;
  cdc_fifo_pkg::count_t  push_count_next;
  cdc_fifo_pkg::count_t  pop_count_prev;
  cdc_fifo_pkg::count_t  pop_count_delta;
  cdc_fifo_pkg::count_t  used_next;
  cdc_fifo_pkg::credit_t credit_count_next;

  // --------------------------------------------------
  // Write path
  // --------------------------------------------------
  // No back-pressure, the sender only pushes with a credit in hand
  assign ram_wr_valid = push_valid;
  assign ram_wr_addr  = push_count[`CDC_FIFO_ADDR_WIDTH-1:0];
  assign ram_wr_data  = push_data;

  assign push_count_next = push_count + cdc_fifo_pkg::count_t'(push_valid);

  // Binary count plus its gray copy, both move on the same edge
  always_ff @(posedge push_clk) begin
    if (rst) begin
      push_count      <= '0;
      push_count_gray <= '0;
    end else begin
      push_count      <= push_count_next;
      push_count_gray <= push_count_next ^ (push_count_next >> 1);
    end
  end

  // --------------------------------------------------
  // Credit receiver
  // --------------------------------------------------
  // Slots freed since last cycle, as seen through the synchronizer
  assign pop_count_delta = pop_count_bin - pop_count_prev;

  always_ff @(posedge push_clk) begin
    if (rst) begin
      pop_count_prev <= '0;
    end else begin
      pop_count_prev <= pop_count_bin;
    end
  end

  // Freed slots come in, each granted credit goes out
  assign credit_count_next = credit_count_push
                           + cdc_fifo_pkg::credit_t'(pop_count_delta)
                           - cdc_fifo_pkg::credit_t'(push_credit);

  // Withheld credits stay in the count but cannot be granted
  assign credit_available_push = (credit_count_push > credit_withhold_push) ?
                                 credit_count_push - credit_withhold_push : '0;

  always_ff @(posedge push_clk) begin
    if (rst) begin
      credit_count_push <= credit_initial_push;
      push_credit       <= 1'b0;
    end else begin
      credit_count_push <= credit_count_next;
      // A grant already on the wire is not yet out of the count
      push_credit <= !push_credit_stall &&
                     (credit_available_push > cdc_fifo_pkg::credit_t'(push_credit));
    end
  end

  // --------------------------------------------------
  // Push-side flags
  // --------------------------------------------------
  // Occupancy against the synchronized pop count, pessimistic by the crossing delay
  assign used_next = push_count_next - pop_count_bin;

  always_ff @(posedge push_clk) begin
    if (rst) begin
      slots <= cdc_fifo_pkg::count_t'(`CDC_FIFO_DEPTH);
      full  <= 1'b0;
    end else begin
      slots <= cdc_fifo_pkg::count_t'(`CDC_FIFO_DEPTH) - used_next;
      full  <= (used_next == cdc_fifo_pkg::count_t'(`CDC_FIFO_DEPTH));
    end
  end

endmodule

//--- verilog/cdc_fifo_ram.sv
// Dual-clock storage with one write port and one registered read port
`include "cdc_fifo_macros.svh"

module cdc_fifo_ram (
  input  logic                push_clk,
  input  logic                pop_clk,

  // Write port, push_clk domain
  input  logic                ram_wr_valid,
  input  cdc_fifo_pkg::addr_t ram_wr_addr,
  input  cdc_fifo_pkg::data_t ram_wr_data,

  // Read port, pop_clk domain
  input  logic                ram_rd_valid,
  input  cdc_fifo_pkg::addr_t ram_rd_addr,
  output cdc_fifo_pkg::data_t ram_rd_data
);

  cdc_fifo_pkg::data_t mem [`CDC_FIFO_DEPTH];

  // Write lands on the same edge as the push
  always_ff @(posedge push_clk) begin
    if (ram_wr_valid) begin
      mem[ram_wr_addr] <= ram_wr_data;
    end
  end

  // One cycle read latency, data holds between reads
  always_ff @(posedge pop_clk) begin
    if (ram_rd_valid) begin
      ram_rd_data <= mem[ram_rd_addr];
    end
  end

endmodule
